// ==== tb.f ====
+incdir+rtl
rtl/uart_dbg_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/dbg_cmd_seq.sv
rtl/dbg_rx_router.sv
rtl/uart_dbg_host.sv
sim/tb_clk_gen.sv
sim/tb_dbg_target.sv
sim/tb_uart_dbg_host.sv

// ==== Makefile ====
TOP := tb_uart_dbg_host

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_uart_dbg_host.sv ====
`timescale 1ns/1ps
`include "uart_dbg_consts.svh"

module tb_uart_dbg_host;

  // Frame budget of all tests with slack for the idle waits
  localparam int frame_cycles = 11 * `UDBG_CLKS_PER_BIT;
  localparam int total_frames = 27 + 27 + 10 + 18 + 8 + 1 + 9;
  localparam int cycle_limit  = 2 * total_frames * frame_cycles;

  logic        clk;
  logic        rst_i;
  logic        cmd_start_i = 1'b0;
  logic [1:0]  cmd_op_i = '0;
  logic [63:0] cmd_addr_i = '0;
  logic [63:0] cmd_len_i = '0;
  logic [7:0]  wr_byte_i = '0;
  logic        wr_req_o, rd_valid_o, busy_o, done_o, err_o, eoc_o, parity_err_o;
  logic [7:0]  rd_byte_o;
  logic [31:0] exit_code_o;
  logic        uart_tx_o, uart_rx_i;

  logic [15:0] lfsr = 16'd5104;
  logic [7:0]  rd_q [$];
  logic [7:0]  wr_q [$];
  bit          done_seen, err_seen, req_seen;
  int          eoc_cnt, perr_cnt, err_cnt, tests_ok, tests_bad, cycles;
  logic [31:0] exit_seen;

  tb_clk_gen i_tb_clk_gen (.clk(clk), .rst_i(rst_i));

  uart_dbg_host #(.parity_ena(1'b1)) i_uart_dbg_host (
    .clk(clk), .rst_i(rst_i), .cmd_start_i(cmd_start_i), .cmd_op_i(cmd_op_i),
    .cmd_addr_i(cmd_addr_i), .cmd_len_i(cmd_len_i), .wr_req_o(wr_req_o),
    .wr_byte_i(wr_byte_i), .rd_byte_o(rd_byte_o), .rd_valid_o(rd_valid_o),
    .busy_o(busy_o), .done_o(done_o), .err_o(err_o), .eoc_o(eoc_o),
    .exit_code_o(exit_code_o), .parity_err_o(parity_err_o),
    .uart_tx_o(uart_tx_o), .uart_rx_i(uart_rx_i)
  );

  tb_dbg_target i_dbg_target (.clk(clk), .host_tx_i(uart_tx_o), .host_rx_o(uart_rx_i));

  // Galois LFSR stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
    end
    return v;
  endfunction

  function automatic logic [7:0] mem_rule(input logic [63:0] a);
    return a[7:0] * 8'd7 + 8'd3;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors and write data feeder
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rd_valid_o) rd_q.push_back(rd_byte_o);
    if (parity_err_o) perr_cnt++;
    if (eoc_o) begin
      eoc_cnt++;
      exit_seen = exit_code_o;
    end
    if (done_o) begin
      done_seen = 1'b1;
      err_seen  = err_o;
    end
  end

  // Byte goes out in the cycle after the request
  always @(posedge clk) begin
    logic [63:0] r;
    #0.5;
    if (req_seen) begin
      r = rand_bits(8);
      wr_byte_i = r[7:0];
      wr_q.push_back(r[7:0]);
    end
    req_seen = wr_req_o;
  end

  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the DUT never finished a test", cycles);
    $display("TEST FAILED");
    $finish;
  end

  task automatic run_cmd(input logic [1:0] op, input logic [63:0] addr, input logic [63:0] len);
    rd_q.delete();
    wr_q.delete();
    done_seen = 1'b0;
    @(posedge clk);
    #0.5;
    cmd_start_i = 1'b1;
    cmd_op_i    = op;
    cmd_addr_i  = addr;
    cmd_len_i   = len;
    @(posedge clk);
    #0.5;
    cmd_start_i = 1'b0;
    check_val("busy_o", busy_o, 1'b1);
    while (!done_seen) @(negedge clk);
    check_val("busy_o", busy_o, 1'b0);
  endtask

  task automatic check_header(input logic [7:0] cmd, input logic [63:0] addr,
                              input logic [63:0] len, input bit with_len);
    check_val("target command byte", i_dbg_target.log_mem[0], cmd);
    for (int i = 0; i < 8; i++) begin
      check_val("target address byte", i_dbg_target.log_mem[1 + i], addr[i*8 +: 8]);
      if (with_len) check_val("target length byte", i_dbg_target.log_mem[9 + i], len[i*8 +: 8]);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      tests_ok++;
      $display("%s: passed", name);
    end else begin
      tests_bad++;
      $display("%s: failed", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [63:0] addr, len, r;
    logic [31:0] code;
    int e;
    @(negedge rst_i);
    repeat (4) @(posedge clk);

    // Write
    e = err_cnt;
    addr = rand_bits(64);
    len = rand_bits(3) + 64'd1;
    run_cmd(`UDBG_OP_WRITE, addr, len);
    check_header(`UDBG_CMD_WRITE, addr, len, 1'b1);
    check_val("write byte count", i_dbg_target.log_cnt, 17 + len);
    check_val("wr_req_o strobes", wr_q.size(), len);
    foreach (wr_q[i]) check_val("target write data", i_dbg_target.log_mem[17 + i], wr_q[i]);
    check_val("err_o", err_seen, 1'b0);
    end_test("write", e);

    // Read
    e = err_cnt;
    addr = rand_bits(64);
    len = rand_bits(3) + 64'd1;
    run_cmd(`UDBG_OP_READ, addr, len);
    check_header(`UDBG_CMD_READ, addr, len, 1'b1);
    check_val("rd_valid_o count", rd_q.size(), len);
    foreach (rd_q[i]) check_val("rd_byte_o", rd_q[i], mem_rule(addr + i));
    check_val("err_o", err_seen, 1'b0);
    end_test("read", e);

    // Exec
    e = err_cnt;
    addr = rand_bits(64);
    run_cmd(`UDBG_OP_EXEC, addr, 64'd1);
    check_header(`UDBG_CMD_EXEC, addr, 64'd0, 1'b0);
    check_val("exec byte count", i_dbg_target.log_cnt, 9);
    check_val("err_o", err_seen, 1'b0);
    check_val("rd_valid_o count", rd_q.size(), 0);
    end_test("exec", e);

    // Reply other than ACK to a write
    e = err_cnt;
    addr = rand_bits(64);
    i_dbg_target.arm_nak();
    run_cmd(`UDBG_OP_WRITE, addr, 64'd4);
    check_val("err_o", err_seen, 1'b1);
    repeat (2 * frame_cycles) @(posedge clk);
    check_val("wr_req_o strobes", wr_q.size(), 0);
    check_val("bad reply byte count", i_dbg_target.log_cnt, 17);
    end_test("bad reply", e);

    // End of computation after some text
    e = err_cnt;
    rd_q.delete();
    r = rand_bits(32);
    code = r[31:0];
    i_dbg_target.send_byte(8'h68);
    i_dbg_target.send_byte(8'h69);
    i_dbg_target.send_byte(8'h0a);
    i_dbg_target.send_byte(`UDBG_EOC);
    for (int i = 0; i < 4; i++) i_dbg_target.send_byte(code[i*8 +: 8]);
    while (eoc_cnt == 0) @(negedge clk);
    repeat (frame_cycles) @(posedge clk);
    check_val("eoc_o count", eoc_cnt, 1);
    check_val("exit_code_o", exit_seen, code);
    check_val("rd_valid_o count", rd_q.size(), 0);
    end_test("end of computation", e);

    // Parity error on one frame
    e = err_cnt;
    check_val("parity_err_o count before", perr_cnt, 0);
    check_val("uart_tx_o parity errors", i_dbg_target.host_par_errs, 0);
    i_dbg_target.arm_bad_parity();
    i_dbg_target.send_byte(8'h41);
    repeat (frame_cycles) @(posedge clk);
    check_val("parity_err_o count", perr_cnt, 1);
    end_test("parity", e);

    $display("tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/tb_dbg_target.sv ====
`timescale 1ns/1ps
`include "uart_dbg_consts.svh"

module tb_dbg_target (
  input  logic clk,
  input  logic host_tx_i,
  output logic host_rx_o
);

  localparam int bit_clks = `UDBG_CLKS_PER_BIT;

  logic [7:0] log_mem [0:63];
  int         log_cnt = 0;
  int         host_par_errs = 0;
  bit         nak_armed = 1'b0;
  bit         bad_par_armed = 1'b0;

  initial host_rx_o = 1'b1;

  task automatic step();
    @(posedge clk);
    #0.5;
  endtask

  // Receive one host frame by mid-bit sampling
  task automatic get_byte(output logic [7:0] b);
    do step(); while (host_tx_i !== 1'b0);
    repeat (bit_clks / 2) step();
    for (int i = 0; i < 10; i++) begin
      repeat (bit_clks) step();
      if (i < 8) b[i] = host_tx_i;
      // Even parity over the data bits
      if ((i == 8) && (host_tx_i !== ^b)) host_par_errs++;
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [10:0] frame;
    frame = {1'b1, (^b) ^ bad_par_armed, b, 1'b0};
    bad_par_armed = 1'b0;
    step();
    for (int i = 0; i < 11; i++) begin
      host_rx_o = frame[i];
      repeat (bit_clks) step();
    end
  endtask

  task automatic arm_nak();
    nak_armed = 1'b1;
  endtask

  task automatic arm_bad_parity();
    bad_par_armed = 1'b1;
  endtask

  function automatic logic [7:0] mem_at(input logic [63:0] a);
    return a[7:0] * 8'd7 + 8'd3;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Protocol responder
  //////////////////////////////////////////////////////////////////////////

  initial begin
    logic [7:0]  b;
    logic [63:0] addr;
    logic [63:0] len;
    int          n;
    forever begin
      get_byte(b);
      log_mem[0] = b;
      log_cnt = 1;
      if (b == `UDBG_CMD_READ || b == `UDBG_CMD_WRITE || b == `UDBG_CMD_EXEC) begin
        n = (b == `UDBG_CMD_EXEC) ? 8 : 16;
        repeat (n) begin
          get_byte(b);
          log_mem[log_cnt] = b;
          log_cnt++;
        end
        for (int i = 0; i < 8; i++) begin
          addr[i*8 +: 8] = log_mem[1 + i];
          len[i*8 +: 8]  = (n == 16) ? log_mem[9 + i] : 8'h00;
        end
        if (nak_armed) begin
          nak_armed = 1'b0;
          send_byte(8'h15);
        end else begin
          send_byte(`UDBG_ACK);
          if (log_mem[0] == `UDBG_CMD_READ) begin
            for (int i = 0; i < len; i++) send_byte(mem_at(addr + i));
            send_byte(`UDBG_EOT);
          end else if (log_mem[0] == `UDBG_CMD_WRITE) begin
            for (int i = 0; i < len; i++) begin
              get_byte(b);
              log_mem[log_cnt] = b;
              log_cnt++;
            end
            send_byte(`UDBG_EOT);
          end
        end
      end
    end
  end

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real period_ns  = 4.0,
  parameter int  rst_cycles = 16
) (
  output logic clk,
  output logic rst_i
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

  // Synchronous reset, released just after an edge
  initial begin
    rst_i = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    #0.5;
    rst_i = 1'b0;
  end

endmodule

// ==== rtl/uart_dbg_host.sv ====
`timescale 1ns/1ps

module uart_dbg_host #(
  parameter bit parity_ena = 1'b0
) (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        cmd_start_i,
  input  logic [1:0]  cmd_op_i,
  input  logic [63:0] cmd_addr_i,
  input  logic [63:0] cmd_len_i,
  output logic        wr_req_o,
  input  logic [7:0]  wr_byte_i,
  output logic [7:0]  rd_byte_o,
  output logic        rd_valid_o,
  output logic        busy_o,
  output logic        done_o,
  output logic        err_o,
  output logic        eoc_o,
  output logic [31:0] exit_code_o,
  output logic        parity_err_o,
  output logic        uart_tx_o,
  input  logic        uart_rx_i
);

  logic                    tx_start;
  logic [7:0]              tx_byte;
  logic                    tx_done;
  logic [7:0]              rx_byte;
  logic                    rx_valid;
  logic                    expect_reply;
  logic [7:0]              reply_byte;
  logic                    reply_valid;
  uart_dbg_pkg::dbg_word_u exit_code;

  //////////////////////////////////////////////////////////////////////////
  // Serial line
  //////////////////////////////////////////////////////////////////////////

  uart_tx #(
    .parity_ena ( parity_ena )
  ) i_uart_tx (
    .clk        ( clk       ),
    .rst_i      ( rst_i     ),
    .tx_start_i ( tx_start  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_o       ( uart_tx_o ),
    .tx_done_o  ( tx_done   )
  );

  uart_rx #(
    .parity_ena ( parity_ena )
  ) i_uart_rx (
    .clk          ( clk          ),
    .rst_i        ( rst_i        ),
    .rx_i         ( uart_rx_i    ),
    .rx_byte_o    ( rx_byte      ),
    .rx_valid_o   ( rx_valid     ),
    .parity_err_o ( parity_err_o )
  );

  //////////////////////////////////////////////////////////////////////////
  // Protocol
  //////////////////////////////////////////////////////////////////////////

  dbg_cmd_seq i_dbg_cmd_seq (
    .clk            ( clk                                       ),
    .rst_i          ( rst_i                                     ),
    .cmd_start_i    ( cmd_start_i                               ),
    .cmd_op_i       ( cmd_op_i                                  ),
    .cmd_addr_i     ( uart_dbg_pkg::dbg_dword_u'(cmd_addr_i)    ),
    .cmd_len_i      ( uart_dbg_pkg::dbg_dword_u'(cmd_len_i)     ),
    .wr_req_o       ( wr_req_o                                  ),
    .wr_byte_i      ( wr_byte_i                                 ),
    .rd_byte_o      ( rd_byte_o                                 ),
    .rd_valid_o     ( rd_valid_o                                ),
    .busy_o         ( busy_o                                    ),
    .done_o         ( done_o                                    ),
    .err_o          ( err_o                                     ),
    .tx_start_o     ( tx_start                                  ),
    .tx_byte_o      ( tx_byte                                   ),
    .tx_done_i      ( tx_done                                   ),
    .expect_reply_o ( expect_reply                              ),
    .reply_byte_i   ( reply_byte                                ),
    .reply_valid_i  ( reply_valid                               )
  );

  dbg_rx_router i_dbg_rx_router (
    .clk            ( clk          ),
    .rst_i          ( rst_i        ),
    .rx_byte_i      ( rx_byte      ),
    .rx_valid_i     ( rx_valid     ),
    .expect_reply_i ( expect_reply ),
    .reply_byte_o   ( reply_byte   ),
    .reply_valid_o  ( reply_valid  ),
    .eoc_o          ( eoc_o        ),
    .exit_code_o    ( exit_code    )
  );

  assign exit_code_o = exit_code.value;

endmodule

// ==== rtl/dbg_rx_router.sv ====
`timescale 1ns/1ps
`include "uart_dbg_consts.svh"

module dbg_rx_router (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic [7:0]              rx_byte_i,
  input  logic                    rx_valid_i,
  input  logic                    expect_reply_i,
  output logic [7:0]              reply_byte_o,
  output logic                    reply_valid_o,
  output logic                    eoc_o,
  output uart_dbg_pkg::dbg_word_u exit_code_o
);

  logic                    reply_valid_q;
  logic [7:0]              reply_byte_q;
  logic                    cap_active_q;
  logic [1:0]              cap_cnt_q;
  logic                    eoc_q;
  uart_dbg_pkg::dbg_word_u exit_q;
  logic                    idle_byte;

  // Byte received outside a command
  assign idle_byte = rx_valid_i && !expect_reply_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      reply_valid_q <= 1'b0;
      cap_active_q  <= 1'b0;
      cap_cnt_q     <= '0;
      eoc_q         <= 1'b0;
    end else begin
      reply_valid_q <= rx_valid_i && expect_reply_i;
      eoc_q         <= 1'b0;
      if (expect_reply_i) begin
        // A new command drops any partial capture
        cap_active_q <= 1'b0;
        cap_cnt_q    <= '0;
      end else if (idle_byte) begin
        if (cap_active_q) begin
          cap_cnt_q <= cap_cnt_q + 2'd1;
          if (cap_cnt_q == 2'd3) begin
            cap_active_q <= 1'b0;
            eoc_q        <= 1'b1;
          end
        end else if (rx_byte_i == `UDBG_EOC) begin
          cap_active_q <= 1'b1;
          cap_cnt_q    <= '0;
        end
        // Plain text bytes fall through here
      end
    end
  end

  // Exit code arrives LSB first
  always_ff @(posedge clk) begin
    reply_byte_q <= rx_byte_i;
    if (idle_byte && cap_active_q) begin
      exit_q.bytes[cap_cnt_q] <= rx_byte_i;
    end
  end

  assign reply_byte_o  = reply_byte_q;
  assign reply_valid_o = reply_valid_q;
  assign eoc_o         = eoc_q;
  assign exit_code_o   = exit_q;

endmodule

// ==== rtl/dbg_cmd_seq.sv ====
`timescale 1ns/1ps
`include "uart_dbg_consts.svh"

module dbg_cmd_seq (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     cmd_start_i,
  input  logic [1:0]               cmd_op_i,
  input  uart_dbg_pkg::dbg_dword_u cmd_addr_i,
  input  uart_dbg_pkg::dbg_dword_u cmd_len_i,
  output logic                     wr_req_o,
  input  logic [7:0]               wr_byte_i,
  output logic [7:0]               rd_byte_o,
  output logic                     rd_valid_o,
  output logic                     busy_o,
  output logic                     done_o,
  output logic                     err_o,
  output logic                     tx_start_o,
  output logic [7:0]               tx_byte_o,
  input  logic                     tx_done_i,
  output logic                     expect_reply_o,
  input  logic [7:0]               reply_byte_i,
  input  logic                     reply_valid_i
);

  localparam logic [3:0] st_idle     = 4'd0;
  localparam logic [3:0] st_hdr_send = 4'd1;
  localparam logic [3:0] st_hdr_wait = 4'd2;
  localparam logic [3:0] st_ack      = 4'd3;
  localparam logic [3:0] st_wr_req   = 4'd4;
  localparam logic [3:0] st_wr_send  = 4'd5;
  localparam logic [3:0] st_wr_wait  = 4'd6;
  localparam logic [3:0] st_rd       = 4'd7;
  localparam logic [3:0] st_eot      = 4'd8;

  logic [3:0]               state_q;
  logic [4:0]               byte_idx_q;
  logic [1:0]               op_q;
  uart_dbg_pkg::dbg_dword_u addr_q;
  uart_dbg_pkg::dbg_dword_u len_q;
  logic                     done_q;
  logic                     err_q;
  logic                     rd_valid_q;
  logic [7:0]               rd_byte_q;
  logic [7:0]               cmd_byte;
  logic [2:0]               byte_sel;
  logic [7:0]               hdr_byte;
  logic                     is_exec;
  logic [4:0]               last_idx;
  logic                     last_data;
  logic                     data_step;

  //////////////////////////////////////////////////////////////////////////
  // Header byte selection
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_q)
      `UDBG_OP_READ:  cmd_byte = `UDBG_CMD_READ;
      `UDBG_OP_WRITE: cmd_byte = `UDBG_CMD_WRITE;
      default:        cmd_byte = `UDBG_CMD_EXEC;
    endcase
  end

  // Index 0 is the command, 1..8 address, 9..16 length
  assign byte_sel = byte_idx_q[2:0] - 3'd1;

  always_comb begin
    if (byte_idx_q == 5'd0) begin
      hdr_byte = cmd_byte;
    end else if (byte_idx_q <= 5'd8) begin
      hdr_byte = addr_q.bytes[byte_sel];
    end else begin
      hdr_byte = len_q.bytes[byte_sel];
    end
  end

  // Exec sends no length
  assign is_exec   = (op_q == `UDBG_OP_EXEC);
  assign last_idx  = is_exec ? 5'd8 : 5'd16;
  assign last_data = (len_q.value == 64'd1);
  assign data_step = ((state_q == st_wr_wait) && tx_done_i) ||
                     ((state_q == st_rd) && reply_valid_i);

  //////////////////////////////////////////////////////////////////////////
  // Transaction FSM
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= st_idle;
      byte_idx_q <= '0;
      done_q     <= 1'b0;
      err_q      <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      done_q     <= 1'b0;
      rd_valid_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (cmd_start_i) begin
            state_q    <= st_hdr_send;
            byte_idx_q <= '0;
            err_q      <= 1'b0;
          end
        end
        st_hdr_send: begin
          state_q <= st_hdr_wait;
        end
        st_hdr_wait: begin
          if (tx_done_i) begin
            if (byte_idx_q == last_idx) begin
              state_q <= st_ack;
            end else begin
              byte_idx_q <= byte_idx_q + 5'd1;
              state_q    <= st_hdr_send;
            end
          end
        end
        st_ack: begin
          if (reply_valid_i) begin
            if (reply_byte_i != `UDBG_ACK) begin
              // Abort without data phase
              state_q <= st_idle;
              done_q  <= 1'b1;
              err_q   <= 1'b1;
            end else if (is_exec) begin
              state_q <= st_idle;
              done_q  <= 1'b1;
            end else if (op_q == `UDBG_OP_WRITE) begin
              state_q <= st_wr_req;
            end else begin
              state_q <= st_rd;
            end
          end
        end
        st_wr_req: begin
          state_q <= st_wr_send;
        end
        st_wr_send: begin
          state_q <= st_wr_wait;
        end
        st_wr_wait: begin
          if (tx_done_i) begin
            state_q <= last_data ? st_eot : st_wr_req;
          end
        end
        st_rd: begin
          if (reply_valid_i) begin
            rd_valid_q <= 1'b1;
            state_q    <= last_data ? st_eot : st_rd;
          end
        end
        st_eot: begin
          if (reply_valid_i) begin
            state_q <= st_idle;
            done_q  <= 1'b1;
            err_q   <= (reply_byte_i != `UDBG_EOT);
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // Command registers, length counts down per data byte
  always_ff @(posedge clk) begin
    if ((state_q == st_idle) && cmd_start_i) begin
      // Unknown op codes run as exec
      if ((cmd_op_i == `UDBG_OP_READ) || (cmd_op_i == `UDBG_OP_WRITE)) begin
        op_q <= cmd_op_i;
      end else begin
        op_q <= `UDBG_OP_EXEC;
      end
      addr_q <= cmd_addr_i;
      len_q  <= cmd_len_i;
    end else if (data_step) begin
      len_q.value <= len_q.value - 64'd1;
    end
    rd_byte_q <= reply_byte_i;
  end

  assign tx_start_o     = (state_q == st_hdr_send) || (state_q == st_wr_send);
  // Write data is sampled by the serializer in the send cycle
  assign tx_byte_o      = (state_q == st_wr_send) ? wr_byte_i : hdr_byte;
  assign wr_req_o       = (state_q == st_wr_req);
  assign busy_o         = (state_q != st_idle);
  assign expect_reply_o = busy_o;
  assign done_o         = done_q;
  assign err_o          = err_q;
  assign rd_valid_o     = rd_valid_q;
  assign rd_byte_o      = rd_byte_q;

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_dbg_consts.svh"

module uart_rx #(
  parameter bit parity_ena = 1'b0
) (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       rx_i,
  output logic [7:0] rx_byte_o,
  output logic       rx_valid_o,
  output logic       parity_err_o
);

  localparam int clks_per_bit = `UDBG_CLKS_PER_BIT;
  localparam int half_bit     = clks_per_bit / 2;
  localparam int cnt_w        = $clog2(clks_per_bit);
  localparam int frame_bits   = parity_ena ? 11 : 10;

  logic             rx_meta_q;
  logic             rx_sync_q;
  logic             rx_prev_q;
  logic             busy_q;
  logic [cnt_w-1:0] cnt_q;
  logic [3:0]       bit_idx_q;
  logic [7:0]       data_q;
  logic             par_q;
  logic             valid_q;
  logic             perr_q;
  logic             sample;

  // Mid-bit sample point
  assign sample = busy_q && (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
      perr_q    <= 1'b0;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
      valid_q   <= 1'b0;
      perr_q    <= 1'b0;
      if (!busy_q) begin
        // Falling edge of the start bit
        if (rx_prev_q && !rx_sync_q) begin
          busy_q    <= 1'b1;
          cnt_q     <= cnt_w'(half_bit - 1);
          bit_idx_q <= '0;
        end
      end else if (!sample) begin
        cnt_q <= cnt_q - cnt_w'(1);
      end else begin
        cnt_q     <= cnt_w'(clks_per_bit - 1);
        bit_idx_q <= bit_idx_q + 4'd1;
        if (bit_idx_q == 4'd0) begin
          // Glitch, line back high at mid start bit
          if (rx_sync_q) begin
            busy_q <= 1'b0;
          end
        end else if (bit_idx_q == 4'(frame_bits - 1)) begin
          busy_q  <= 1'b0;
          valid_q <= 1'b1;
          perr_q  <= parity_ena && (par_q != ^data_q);
        end
      end
    end
  end

  // Data shifts in LSB first
  always_ff @(posedge clk) begin
    if (sample && (bit_idx_q >= 4'd1) && (bit_idx_q <= 4'd8)) begin
      data_q <= {rx_sync_q, data_q[7:1]};
    end
    if (sample && parity_ena && (bit_idx_q == 4'd9)) begin
      par_q <= rx_sync_q;
    end
  end

  assign rx_byte_o    = data_q;
  assign rx_valid_o   = valid_q;
  assign parity_err_o = perr_q;

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_dbg_consts.svh"

module uart_tx #(
  parameter bit parity_ena = 1'b0
) (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       tx_start_i,
  input  logic [7:0] tx_byte_i,
  output logic       tx_o,
  output logic       tx_done_o
);

  localparam int clks_per_bit = `UDBG_CLKS_PER_BIT;
  localparam int cnt_w        = $clog2(clks_per_bit);
  localparam int frame_bits   = parity_ena ? 11 : 10;

  logic             busy_q;
  logic [cnt_w-1:0] baud_cnt_q;
  logic [3:0]       bit_cnt_q;
  logic [10:0]      frame_q;
  logic             tx_q;
  logic             done_q;
  logic             par_or_stop;

  // Slot 9 holds parity, or the stop bit without parity
  assign par_or_stop = parity_ena ? ^tx_byte_i : 1'b1;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q     <= 1'b0;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_q       <= 1'b1;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (tx_start_i) begin
          busy_q     <= 1'b1;
          baud_cnt_q <= '0;
          bit_cnt_q  <= '0;
          // Start bit
          tx_q       <= 1'b0;
        end
      end else if (baud_cnt_q == cnt_w'(clks_per_bit - 1)) begin
        baud_cnt_q <= '0;
        if (bit_cnt_q == 4'(frame_bits - 1)) begin
          // End of stop bit
          busy_q <= 1'b0;
          done_q <= 1'b1;
          tx_q   <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
          tx_q      <= frame_q[bit_cnt_q + 4'd1];
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + cnt_w'(1);
      end
    end
  end

  // Frame image, data LSB first after the start bit
  always_ff @(posedge clk) begin
    if (!busy_q && tx_start_i) begin
      frame_q <= {1'b1, par_or_stop, tx_byte_i, 1'b0};
    end
  end

  assign tx_o      = tx_q;
  assign tx_done_o = done_q;

endmodule

// ==== rtl/uart_dbg_pkg.sv ====
package uart_dbg_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Multi-byte protocol words
  //////////////////////////////////////////////////////////////////////////

  // Address or length, counted as a value and sent byte by byte
  typedef union packed {
    logic [63:0]     value;
    logic [7:0][7:0] bytes;
  } dbg_dword_u;

  // Exit code, gathered byte by byte and read out as a value
  typedef union packed {
    logic [31:0]     value;
    logic [3:0][7:0] bytes;
  } dbg_word_u;

endpackage

// ==== rtl/uart_dbg_consts.svh ====
`ifndef UDBG_CONSTS_SVH
`define UDBG_CONSTS_SVH

// Clock cycles per UART bit
`define UDBG_CLKS_PER_BIT 8

// Command bytes sent by the host
`define UDBG_CMD_READ  8'h11
`define UDBG_CMD_WRITE 8'h12
`define UDBG_CMD_EXEC  8'h13

// Reply bytes from the target
`define UDBG_ACK 8'h06
`define UDBG_EOT 8'h04
`define UDBG_EOC 8'h14

// Operation codes on the command port
`define UDBG_OP_READ  2'd0
`define UDBG_OP_WRITE 2'd1
`define UDBG_OP_EXEC  2'd2

`endif
